/* hdl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CORE_XLEN   32
`define CORE_NREGS  16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction type codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CORE_T_NOP  4'd0
`define CORE_T_ALU  4'd1
`define CORE_T_LDI  4'd2
`define CORE_T_MOV  4'd3
`define CORE_T_CMP  4'd4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu op codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CORE_OP_ADD 4'd0
`define CORE_OP_SUB 4'd1
`define CORE_OP_AND 4'd2
`define CORE_OP_OR  4'd3
`define CORE_OP_XOR 4'd4
`define CORE_OP_SHL 4'd5
`define CORE_OP_SHR 4'd6

`endif

/* hdl/core_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]          word_t;
  typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;
  typedef logic [1:0]                     wmask_t;   // bit 0 low half, bit 1 high half.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    reg_addr_t   rc;
    logic [11:0] rsvd;
  } rc_field_t;

  typedef union packed {
    rc_field_t   r;
    logic [15:0] imm16;    // shares the rc bits.
  } lo16_t;

  typedef struct packed {
    logic [3:0] ir_type;
    logic [3:0] op;
    reg_addr_t  ra;
    reg_addr_t  rb;
    lo16_t      lo;
  } instr_t;

  typedef struct packed {
    logic eq;
    logic lt;              // signed.
    logic ltu;
  } flags_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic   valid;
    word_t  pc;
    instr_t ir;
  } fetch_bundle_t;

  typedef struct packed {
    logic   valid;
    word_t  pc;
    instr_t ir;
    word_t  opa;
    word_t  opb;
    wmask_t wmask;
  } dec_bundle_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t dest;
    wmask_t    wmask;
    word_t     result;
    logic      is_cmp;
    flags_t    flags;
  } exe_bundle_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t dest;
    wmask_t    wmask;
    word_t     data;
  } wb_t;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
`default_nettype none

module fetch_stage
  import core_pkg::*;
(
  input  wire           clk_i,
  input  wire           rst_i,
  input  wire instr_t   ir_i,
  input  wire           ir_valid_i,
  input  wire           stall_i,
  output fetch_bundle_t fetch_o
);

  word_t pc_q;     // pc of the next accepted word.
  logic  accept;

  assign accept = ir_valid_i && !stall_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      pc_q    <= '0;
      fetch_o <= '0;
    end
    else
    begin
      if (!stall_i)
      begin
        fetch_o.valid <= ir_valid_i;
        fetch_o.pc    <= pc_q;
        fetch_o.ir    <= ir_valid_i ? ir_i : '0;   // bubble carries a zero word.
      end
      if (accept)
      begin
        pc_q <= pc_q + word_t'(4);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`default_nettype none

`include "core_macros.svh"

module register_file
  import core_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_i,
  input  wire reg_addr_t rd_addr1_i,
  input  wire reg_addr_t rd_addr2_i,
  output word_t          rd_data1_o,
  output word_t          rd_data2_o,
  input  wire reg_addr_t wr_addr_i,
  input  wire wmask_t    wr_mask_i,
  input  wire word_t     wr_data_i
);

  word_t regs [`CORE_NREGS];

  // replace the lanes selected by the mask.
  function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
                                        input wmask_t m);
    word_t w;
    w = old_w;
    if (m[0])
      w[`CORE_XLEN/2-1:0] = new_w[`CORE_XLEN/2-1:0];
    if (m[1])
      w[`CORE_XLEN-1:`CORE_XLEN/2] = new_w[`CORE_XLEN-1:`CORE_XLEN/2];
    return w;
  endfunction

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      regs <= '{default: '0};
    end
    else if (|wr_mask_i)
    begin
      regs[wr_addr_i] <= merge_lanes(regs[wr_addr_i], wr_data_i, wr_mask_i);
    end
  end

  // same-cycle write shows through on the read ports.
  assign rd_data1_o = (rd_addr1_i == wr_addr_i) ?
                      merge_lanes(regs[rd_addr1_i], wr_data_i, wr_mask_i) : regs[rd_addr1_i];
  assign rd_data2_o = (rd_addr2_i == wr_addr_i) ?
                      merge_lanes(regs[rd_addr2_i], wr_data_i, wr_mask_i) : regs[rd_addr2_i];

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`default_nettype none

`include "core_macros.svh"

module decode_stage
  import core_pkg::*;
(
  input  wire                clk_i,
  input  wire                rst_i,
  input  wire                stall_i,
  input  wire fetch_bundle_t fetch_i,
  output reg_addr_t          rd_addr1_o,
  output reg_addr_t          rd_addr2_o,
  input  wire word_t         rd_data1_i,
  input  wire word_t         rd_data2_i,
  output dec_bundle_t        dec_o
);

  instr_t ir;
  logic   is_cmp;
  wmask_t wmask_d;

  assign ir     = fetch_i.ir;
  assign is_cmp = (ir.ir_type == `CORE_T_CMP);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rd_addr1_o = is_cmp ? ir.ra : ir.rb;
  assign rd_addr2_o = is_cmp ? ir.rb : ir.lo.r.rc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write lanes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    case (ir.ir_type)
      `CORE_T_ALU,
      `CORE_T_LDI:
        wmask_d = 2'b11;
      `CORE_T_MOV:
        wmask_d = ir.op[1:0];          // lanes come from the op field.
      `CORE_T_NOP,
      `CORE_T_CMP:
        wmask_d = 2'b00;
      default:
        wmask_d = 2'b00;
    endcase
    if (!fetch_i.valid)
    begin
      wmask_d = 2'b00;                 // bubbles never write.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      dec_o <= '0;
    end
    else if (!stall_i)
    begin
      dec_o.valid <= fetch_i.valid;
      dec_o.pc    <= fetch_i.pc;
      dec_o.ir    <= ir;
      dec_o.opa   <= rd_data1_i;
      dec_o.opb   <= rd_data2_i;
      dec_o.wmask <= wmask_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`default_nettype none

`include "core_macros.svh"

module execute_stage
  import core_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_i,
  input  wire              stall_i,
  input  wire dec_bundle_t dec_i,
  output exe_bundle_t      exe_o
);

  instr_t                         ir;
  logic [$clog2(`CORE_XLEN)-1:0]  shamt;
  word_t                          alu_res;
  word_t                          lane_bits;
  word_t                          result_d;
  flags_t                         flags_d;

  assign ir        = dec_i.ir;
  assign shamt     = dec_i.opb[$clog2(`CORE_XLEN)-1:0];
  assign lane_bits = {{(`CORE_XLEN/2){dec_i.wmask[1]}}, {(`CORE_XLEN/2){dec_i.wmask[0]}}};

  always_comb
  begin
    case (ir.op)
      `CORE_OP_ADD: alu_res = dec_i.opa + dec_i.opb;
      `CORE_OP_SUB: alu_res = dec_i.opa - dec_i.opb;
      `CORE_OP_AND: alu_res = dec_i.opa & dec_i.opb;
      `CORE_OP_OR:  alu_res = dec_i.opa | dec_i.opb;
      `CORE_OP_XOR: alu_res = dec_i.opa ^ dec_i.opb;
      `CORE_OP_SHL: alu_res = dec_i.opa << shamt;
      `CORE_OP_SHR: alu_res = dec_i.opa >> shamt;   // logical.
      default:      alu_res = '0;
    endcase
  end

  always_comb
  begin
    case (ir.ir_type)
      `CORE_T_ALU:
        result_d = alu_res;
      `CORE_T_LDI:
        result_d = {{(`CORE_XLEN-16){ir.lo.imm16[15]}}, ir.lo.imm16};
      `CORE_T_MOV:
        result_d = dec_i.opb & lane_bits;          // only the moved lanes.
      default:
        result_d = '0;
    endcase
  end

  assign flags_d.eq  = (dec_i.opa == dec_i.opb);
  assign flags_d.lt  = ($signed(dec_i.opa) < $signed(dec_i.opb));
  assign flags_d.ltu = (dec_i.opa < dec_i.opb);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      exe_o <= '0;
    end
    else if (!stall_i)
    begin
      exe_o.valid  <= dec_i.valid;
      exe_o.pc     <= dec_i.pc;
      exe_o.dest   <= ir.ra;
      exe_o.wmask  <= dec_i.wmask;
      exe_o.result <= result_d;
      exe_o.is_cmp <= dec_i.valid && (ir.ir_type == `CORE_T_CMP);
      exe_o.flags  <= flags_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/writeback_stage.sv */
`default_nettype none

module writeback_stage
  import core_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_i,
  input  wire              stall_i,
  input  wire exe_bundle_t exe_i,
  output reg_addr_t        wr_addr_o,
  output wmask_t           wr_mask_o,
  output word_t            wr_data_o,
  output wb_t              wb_o,
  output flags_t           flags_o
);

  logic retire;

  assign retire = exe_i.valid && !stall_i;

  // register file write port.
  assign wr_addr_o = exe_i.dest;
  assign wr_mask_o = retire ? exe_i.wmask : 2'b00;
  assign wr_data_o = exe_i.result;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wb_o    <= '0;
      flags_o <= '0;
    end
    else
    begin
      wb_o.valid <= retire;              // low through stalled cycles.
      if (!stall_i)
      begin
        wb_o.pc    <= exe_i.pc;
        wb_o.dest  <= exe_i.dest;
        wb_o.wmask <= exe_i.wmask;
        wb_o.data  <= exe_i.result;
      end
      if (retire && exe_i.is_cmp)
      begin
        flags_o <= exe_i.flags;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`default_nettype none

module core_top
  import core_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire instr_t ir_i,
  input  wire         ir_valid_i,
  input  wire         stall_i,
  output wb_t         wb_o,
  output flags_t      flags_o
);

  fetch_bundle_t fetch_b;
  dec_bundle_t   dec_b;
  exe_bundle_t   exe_b;
  reg_addr_t     rd_addr1;
  reg_addr_t     rd_addr2;
  word_t         rd_data1;
  word_t         rd_data2;
  reg_addr_t     wr_addr;
  wmask_t        wr_mask;
  word_t         wr_data;

  fetch_stage u_fetch (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ir_i       (ir_i),
    .ir_valid_i (ir_valid_i),
    .stall_i    (stall_i),
    .fetch_o    (fetch_b)
  );

  decode_stage u_decode (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .fetch_i    (fetch_b),
    .rd_addr1_o (rd_addr1),
    .rd_addr2_o (rd_addr2),
    .rd_data1_i (rd_data1),
    .rd_data2_i (rd_data2),
    .dec_o      (dec_b)
  );

  register_file u_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_addr1_i (rd_addr1),
    .rd_addr2_i (rd_addr2),
    .rd_data1_o (rd_data1),
    .rd_data2_o (rd_data2),
    .wr_addr_i  (wr_addr),
    .wr_mask_i  (wr_mask),
    .wr_data_i  (wr_data)
  );

  execute_stage u_execute (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .dec_i      (dec_b),
    .exe_o      (exe_b)
  );

  writeback_stage u_writeback (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .exe_i      (exe_b),
    .wr_addr_o  (wr_addr),
    .wr_mask_o  (wr_mask),
    .wr_data_o  (wr_data),
    .wb_o       (wb_o),
    .flags_o    (flags_o)
  );

endmodule

`default_nettype wire

/* test/core_tb.sv */
`default_nettype none

`include "core_macros.svh"

module core_tb
  import core_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    wb_t         wb;
    flags_t      flags;
    logic        is_cmp;
    logic [31:0] edge_no;              // unstalled edge count at acceptance.
  } expect_t;

  logic   clk_i = 1'b0;
  logic   rst_i;
  instr_t ir_i;
  logic   ir_valid_i;
  logic   stall_i;
  wb_t    wb_o;
  flags_t flags_o;

  logic [31:0] rng_state = 32'h5764_ec2a;
  logic [31:0] shadow [16];
  logic [31:0] model_pc;
  flags_t      cur_flags;
  expect_t     exp_q [$];
  logic        last_stalled;
  int unsigned unstalled_edges;
  int unsigned accepted;
  int unsigned retired;
  int unsigned checks;
  int unsigned errors;

  core_top DUT (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ir_i       (ir_i),
    .ir_valid_i (ir_valid_i),
    .stall_i    (stall_i),
    .wb_o       (wb_o),
    .flags_o    (flags_o)
  );

  always #20 clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random numbers and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return r[31:8] % n;                // upper bits are the better ones.
  endfunction

  function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      `CORE_OP_ADD: return a + b;
      `CORE_OP_SUB: return a - b;
      `CORE_OP_AND: return a & b;
      `CORE_OP_OR:  return a | b;
      `CORE_OP_XOR: return a ^ b;
      `CORE_OP_SHL: return a << b[4:0];
      `CORE_OP_SHR: return a >> b[4:0];
      default:      return '0;
    endcase
  endfunction

  // computes the retirement of one accepted word and updates the shadow registers.
  function automatic expect_t model_instr(input logic [31:0] w);
    expect_t     e;
    logic [3:0]  op;
    logic [3:0]  ra;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    op = w[27:24];
    ra = w[23:20];
    a  = shadow[w[19:16]];
    b  = shadow[w[15:12]];
    e  = '0;
    e.wb.valid = 1'b1;
    e.wb.pc    = model_pc;
    e.wb.dest  = ra;
    model_pc   = model_pc + 32'd4;
    case (w[31:28])
      `CORE_T_ALU:
      begin
        v = alu_ref(op, a, b);
        e.wb.wmask = 2'b11;
        e.wb.data  = v;
        shadow[ra] = v;
      end
      `CORE_T_LDI:
      begin
        v = {{16{w[15]}}, w[15:0]};
        e.wb.wmask = 2'b11;
        e.wb.data  = v;
        shadow[ra] = v;
      end
      `CORE_T_MOV:
      begin
        v = '0;
        if (op[0])
        begin
          v[15:0] = b[15:0];
          shadow[ra][15:0] = b[15:0];
        end
        if (op[1])
        begin
          v[31:16] = b[31:16];
          shadow[ra][31:16] = b[31:16];
        end
        e.wb.wmask = op[1:0];
        e.wb.data  = v;
      end
      `CORE_T_CMP:
      begin
        a = shadow[ra];
        b = shadow[w[19:16]];
        e.is_cmp    = 1'b1;
        e.flags.eq  = (a == b);
        e.flags.lt  = ($signed(a) < $signed(b));
        e.flags.ltu = (a < b);
      end
      default:
      begin
      end
    endcase
    return e;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic step(input logic stall_lvl, input logic valid_lvl, input logic [31:0] word);
    expect_t e;
    @(negedge clk_i);
    stall_i    = stall_lvl;
    ir_valid_i = valid_lvl;
    ir_i       = word;
    if (valid_lvl && !stall_lvl)
      e = model_instr(word);
    @(posedge clk_i);
    last_stalled = stall_lvl;
    if (!stall_lvl)
      unstalled_edges++;
    if (valid_lvl && !stall_lvl)
    begin
      e.edge_no = unstalled_edges;
      exp_q.push_back(e);
      accepted++;
    end
  endtask

  function automatic logic [31:0] ldi(input logic [3:0] ra, input logic [15:0] imm);
    return {`CORE_T_LDI, 4'd0, ra, 4'd0, imm};
  endfunction

  // MOV into r1 from r2 for each lane mask, then r3 = r1 | r15 shows the merge.
  task automatic run_mov_checks();
    int unsigned m;
    for (m = 1; m <= 3; m++)
    begin
      step(1'b0, 1'b1, ldi(4'd1, 16'h8765));
      step(1'b0, 1'b1, ldi(4'd2, 16'h1234));
      step(1'b0, 1'b0, '0);
      step(1'b0, 1'b1, {`CORE_T_MOV, 4'(m), 4'd1, 4'd0, 4'd2, 12'h0});
      step(1'b0, 1'b0, '0);
      step(1'b0, 1'b1, {`CORE_T_ALU, `CORE_OP_OR, 4'd3, 4'd1, 4'd15, 12'h0});
      step(1'b0, 1'b0, '0);
    end
  endtask

  task automatic run_random(input int unsigned slots);
    int unsigned i;
    int unsigned s;
    int unsigned n;
    logic [3:0]  t;
    logic [3:0]  op;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [3:0]  last_dest;
    logic        has_last;
    logic [31:0] w;
    has_last  = 1'b0;
    last_dest = '0;
    for (i = 0; i < slots; i++)
    begin
      if (pick(8) == 0)
      begin
        n = 1 + pick(4);
        for (s = 0; s < n; s++)
          step(1'b1, 1'(pick(2)), next_rand());   // ignored while stalled.
      end
      if (pick(6) == 0)
      begin
        step(1'b0, 1'b0, next_rand());
        has_last = 1'b0;
      end
      else
      begin
        t  = 4'(pick(5));
        ra = 4'(pick(15));                         // r15 stays zero.
        rb = 4'(pick(16));
        rc = 4'(pick(16));
        if (has_last && rb == last_dest)
          rb = rb + 4'd1;
        if (has_last && rc == last_dest)
          rc = rc + 4'd1;
        if (t == `CORE_T_CMP && has_last && ra == last_dest)
          ra = ra + 4'd1;
        case (t)
          `CORE_T_ALU: op = 4'(pick(7));
          `CORE_T_MOV: op = 4'(1 + pick(3));
          default:     op = 4'(pick(16));
        endcase
        w = next_rand();
        if (t == `CORE_T_LDI)
          w = {t, op, ra, rb, w[15:0]};
        else
          w = {t, op, ra, rb, rc, w[11:0]};
        step(1'b0, 1'b1, w);
        has_last  = (t == `CORE_T_ALU) || (t == `CORE_T_LDI) || (t == `CORE_T_MOV);
        last_dest = ra;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
    checks++;
    assert (got_v === exp_v)
    else
    begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
    end
  endtask

  always @(negedge clk_i)
  begin : retire_check
    expect_t e;
    if (rst_i)
    begin
      compare_value("wb_o.valid", 32'd0, wb_o.valid);
      compare_value("flags_o", 32'd0, flags_o);
    end
    else
    begin
      checks++;
      assert (!(last_stalled && wb_o.valid))
      else
      begin
        errors++;
        $display("Error at %0t ns: a retirement was reported after a stalled edge", $time);
      end
      if (wb_o.valid)
      begin
        retired++;                     // every pulse counts.
        checks++;
        assert (exp_q.size() != 0)
        else
        begin
          errors++;
          $display("Error at %0t ns: a retirement came with no instruction outstanding",
                   $time);
        end
        if (exp_q.size() != 0)
        begin
          e = exp_q.pop_front();
          compare_value("wb_o.pc", e.wb.pc, wb_o.pc);
          compare_value("wb_o.dest", e.wb.dest, wb_o.dest);
          compare_value("wb_o.wmask", e.wb.wmask, wb_o.wmask);
          compare_value("wb_o.data", e.wb.data, wb_o.data);
          compare_value("unstalled edges to wb_o.valid", e.edge_no + 32'd3,
                        unstalled_edges);
          if (e.is_cmp)
            cur_flags = e.flags;
        end
      end
      compare_value("flags_o", cur_flags, flags_o);   // holds between compares.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    int unsigned idle;
    rst_i           = 1'b1;
    stall_i         = 1'b0;
    ir_valid_i      = 1'b0;
    ir_i            = '0;
    shadow          = '{default: '0};
    model_pc        = '0;
    cur_flags       = '0;
    last_stalled    = 1'b0;
    unstalled_edges = 0;
    accepted        = 0;
    retired         = 0;
    checks          = 0;
    errors          = 0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    run_mov_checks();
    run_random(300);

    idle = 0;
    while (exp_q.size() != 0 && idle < 20)       // drain the pipeline.
    begin
      step(1'b0, 1'b0, '0);
      idle++;
    end
    checks++;
    assert (exp_q.size() == 0)
    else
    begin
      errors++;
      $display("Error: %0d accepted instructions did not retire within 20 cycles",
               exp_q.size());
    end
    for (idle = 0; idle < 4; idle++)
      step(1'b0, 1'b0, '0);
    checks++;
    assert (accepted == retired)
    else
    begin
      errors++;
      $display("Error: %0d instructions accepted but %0d retired", accepted, retired);
    end

    $display("checks %0d, errors %0d, accepted %0d, retired %0d",
             checks, errors, accepted, retired);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
test/core_tb.sv

/* Bender.yml */
package:
  name: core

export_include_dirs:
  - hdl

sources:
  - hdl/core_pkg.sv
  - hdl/fetch_stage.sv
  - hdl/register_file.sv
  - hdl/decode_stage.sv
  - hdl/execute_stage.sv
  - hdl/writeback_stage.sv
  - hdl/core_top.sv
  - target: test
    files:
      - test/core_tb.sv
